// File: Makefile
VERILATOR ?= verilator
TOP       ?= uart_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: flist.f
hw/uart_pkg.sv
hw/baud_gen.sv
hw/uart_rx.sv
hw/rx_buffer.sv
hw/uart_tx.sv
hw/tx_buffer.sv
hw/uart_top.sv
verif/tb_clock.sv
verif/uart_assert.sv
verif/uart_tb.sv

// File: hw/baud_gen.sv
`timescale 1ns/10ps
`default_nettype none

module baud_gen #(
	parameter uart_pkg::div_t clk_div = 16'd4
) (
	input  wire  clk,
	input  wire  rst_n,
	output logic tick
);
	import uart_pkg::*;

	// Count runs from clk_div-1 down to zero
	localparam div_t reload = clk_div - div_t'(1);

	// Down-counter state
	div_t cnt;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			// Restart a full period after reset
			cnt <= reload;
		end
		else if (cnt == '0)
		begin
			// Wrap back to the top
			cnt <= reload;
		end
		else
		begin
			cnt <= cnt - 1'b1;
		end
	end

	// One cycle high per wrap
	// With clk_div of 1 the count stays at zero and tick is always high
	assign tick = (cnt == '0);

endmodule

`default_nettype wire

// File: hw/rx_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module rx_buffer (
	input  wire             clk,
	input  wire             rst_n,
	input  wire             rx_done,
	input  wire  uart_pkg::data_t rx_byte,
	input  wire             rd,
	output uart_pkg::data_t r_data,
	output logic            rx_empty,
	output logic            rx_overrun
);

	// Read only counts while a byte is held
	logic rd_ok;

	assign rd_ok = rd & ~rx_empty;

	//////////////////////////////////////////////////
	// Empty flag and overrun pulse
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			rx_empty   <= 1'b1;
			rx_overrun <= 1'b0;
		end
		else
		begin
			// Capture into a full register that is not being read
			// in the same cycle loses the old byte
			rx_overrun <= rx_done & ~rx_empty & ~rd;

			if (rx_done)
			begin
				// Capture wins over a read in the same cycle
				rx_empty <= 1'b0;
			end
			else if (rd_ok)
			begin
				rx_empty <= 1'b1;
			end
		end
	end

	// Holding register
	// Loaded on every done strobe, overwrite when full
	always_ff @(posedge clk)
	begin
		if (rx_done)
			r_data <= rx_byte;
	end

endmodule

`default_nettype wire

// File: hw/tx_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module tx_buffer (
	input  wire             clk,
	input  wire             rst_n,
	input  wire             wr,
	input  wire  uart_pkg::data_t w_data,
	input  wire             tx_busy,
	output logic            tx_full,
	output logic            tx_start,
	output uart_pkg::data_t tx_byte
);

	// Write is dropped while the register is full
	logic wr_ok;

	// Held byte and an idle serializer
	logic release_ok;

	assign wr_ok      = wr & ~tx_full;
	assign release_ok = tx_full & ~tx_busy;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			tx_full  <= 1'b0;
			tx_start <= 1'b0;
		end
		else
		begin
			// One-cycle strobe, full clears on the same edge
			tx_start <= release_ok;
			if (release_ok)
				tx_full <= 1'b0;
			else if (wr_ok)
				tx_full <= 1'b1;
		end
	end

	// Serializer latches on tx_start, so a new write may land the cycle after
	always_ff @(posedge clk)
	begin
		if (wr_ok)
			tx_byte <= w_data;
	end

endmodule

`default_nettype wire

// File: hw/uart_pkg.sv
`default_nettype none

package uart_pkg;

	//////////////////////////////////////////////////
	// Data and counter types
	//////////////////////////////////////////////////

	// One serial data byte
	typedef logic [7:0] data_t;

	// Divider count, clock cycles per oversample tick
	typedef logic [15:0] div_t;

	//////////////////////////////////////////////////
	// Serial frame constants
	//////////////////////////////////////////////////

	// Ticks per bit time
	localparam int unsigned OVERSAMPLE = 16;

	// Data bits per frame, no parity, one stop bit
	localparam int unsigned DATA_BITS = 8;

	// Receiver states
	typedef enum logic [1:0] {
		rx_idle,
		rx_start,
		rx_data,
		rx_stop
	} rx_state_t;

	// Transmitter states
	typedef enum logic [1:0] {
		tx_idle,
		tx_start,
		tx_data,
		tx_stop
	} tx_state_t;

endpackage

`default_nettype wire

// File: hw/uart_rx.sv
`timescale 1ns/10ps
`default_nettype none

module uart_rx (
	input  wire             clk,
	input  wire             rst_n,
	input  wire             rx,
	input  wire             tick,
	output logic            rx_done,
	output uart_pkg::data_t rx_byte,
	output logic            frame_err
);
	import uart_pkg::*;

	localparam int unsigned tick_w = $clog2(OVERSAMPLE);
	localparam int unsigned bit_w = $clog2(DATA_BITS);

	// Half a bit time for the start check, a full bit time per sample
	localparam logic [tick_w-1:0] mid_tick = tick_w'(OVERSAMPLE / 2 - 1);
	localparam logic [tick_w-1:0] last_tick = tick_w'(OVERSAMPLE - 1);
	localparam logic [bit_w-1:0] last_bit = bit_w'(DATA_BITS - 1);

	rx_state_t state;
	logic [tick_w-1:0] tick_cnt;
	logic [bit_w-1:0] bit_cnt;

	// Two-flop synchronizer and edge history
	logic rx_meta;
	logic rx_sync;
	logic rx_prev;

	logic fall;
	logic sample;

	//////////////////////////////////////////////////
	// Input synchronizer
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			// Idle line is high, so no false edge out of reset
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end
		else
		begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	// High to low on the synchronized line
	assign fall = rx_prev & ~rx_sync;

	// Bit-centre sample point in data and stop states
	assign sample = tick && (tick_cnt == last_tick);

	//////////////////////////////////////////////////
	// Receive FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state     <= rx_idle;
			tick_cnt  <= '0;
			bit_cnt   <= '0;
			rx_done   <= 1'b0;
			frame_err <= 1'b0;
		end
		else
		begin
			// Strobes last one cycle
			rx_done   <= 1'b0;
			frame_err <= 1'b0;
			case (state)
				rx_idle:
				begin
					if (fall)
					begin
						state    <= rx_start;
						tick_cnt <= '0;
					end
				end
				rx_start:
				begin
					if (tick)
					begin
						if (tick_cnt == mid_tick)
						begin
							// Still low at mid-bit, else a glitch
							tick_cnt <= '0;
							bit_cnt  <= '0;
							state    <= rx_sync ? rx_idle : rx_data;
						end
						else
						begin
							tick_cnt <= tick_cnt + 1'b1;
						end
					end
				end
				rx_data:
				begin
					if (sample)
					begin
						tick_cnt <= '0;
						if (bit_cnt == last_bit)
							state <= rx_stop;
						else
							bit_cnt <= bit_cnt + 1'b1;
					end
					else if (tick)
					begin
						tick_cnt <= tick_cnt + 1'b1;
					end
				end
				rx_stop:
				begin
					if (sample)
					begin
						tick_cnt <= '0;
						state    <= rx_idle;
						// Good stop bit gives done, low stop bit gives framing error
						if (rx_sync)
							rx_done <= 1'b1;
						else
							frame_err <= 1'b1;
					end
					else if (tick)
					begin
						tick_cnt <= tick_cnt + 1'b1;
					end
				end
				default:
				begin
					state <= rx_idle;
				end
			endcase
		end
	end

	// LSB first, so each new bit enters at the top
	always_ff @(posedge clk)
	begin
		if (state == rx_data && sample)
			rx_byte <= {rx_sync, rx_byte[DATA_BITS-1:1]};
	end

endmodule

`default_nettype wire

// File: hw/uart_top.sv
`timescale 1ns/10ps
`default_nettype none

module uart_top #(
	parameter uart_pkg::div_t clk_div = 16'd4
) (
	input  wire             clk,
	input  wire             rst_n,
	// Serial pins
	input  wire             rx,
	output logic            tx,
	// Receive side
	input  wire             rd,
	output uart_pkg::data_t r_data,
	output logic            rx_empty,
	output logic            rx_overrun,
	output logic            frame_err,
	// Transmit side
	input  wire             wr,
	input  wire  uart_pkg::data_t w_data,
	output logic            tx_full
);
	import uart_pkg::*;

	// Oversample pacing for both directions
	logic tick;

	// Receiver to holding register
	logic rx_done;
	data_t rx_byte;

	// Holding register to serializer
	logic tx_start;
	data_t tx_byte;
	logic tx_busy;

	//////////////////////////////////////////////////
	// Tick generator
	//////////////////////////////////////////////////

	baud_gen #(
		.clk_div (clk_div)
	) u_baud_gen (
		.clk   (clk),
		.rst_n (rst_n),
		.tick  (tick)
	);

	//////////////////////////////////////////////////
	// Receive path
	//////////////////////////////////////////////////

	uart_rx u_uart_rx (
		.clk       (clk),
		.rst_n     (rst_n),
		.rx        (rx),
		.tick      (tick),
		.rx_done   (rx_done),
		.rx_byte   (rx_byte),
		.frame_err (frame_err)
	);

	rx_buffer u_rx_buffer (
		.clk        (clk),
		.rst_n      (rst_n),
		.rx_done    (rx_done),
		.rx_byte    (rx_byte),
		.rd         (rd),
		.r_data     (r_data),
		.rx_empty   (rx_empty),
		.rx_overrun (rx_overrun)
	);

	//////////////////////////////////////////////////
	// Transmit path
	//////////////////////////////////////////////////

	tx_buffer u_tx_buffer (
		.clk      (clk),
		.rst_n    (rst_n),
		.wr       (wr),
		.w_data   (w_data),
		.tx_busy  (tx_busy),
		.tx_full  (tx_full),
		.tx_start (tx_start),
		.tx_byte  (tx_byte)
	);

	uart_tx u_uart_tx (
		.clk      (clk),
		.rst_n    (rst_n),
		.tick     (tick),
		.tx_start (tx_start),
		.tx_byte  (tx_byte),
		.tx       (tx),
		.tx_busy  (tx_busy)
	);

endmodule

`default_nettype wire

// File: hw/uart_tx.sv
`timescale 1ns/10ps
`default_nettype none

module uart_tx (
	input  wire             clk,
	input  wire             rst_n,
	input  wire             tick,
	input  wire             tx_start,
	input  wire  uart_pkg::data_t tx_byte,
	output logic            tx,
	output logic            tx_busy
);
	import uart_pkg::*;

	localparam int unsigned tick_w = $clog2(OVERSAMPLE);
	localparam int unsigned bit_w = $clog2(DATA_BITS);
	localparam logic [tick_w-1:0] last_tick = tick_w'(OVERSAMPLE - 1);
	localparam logic [bit_w-1:0] last_bit = bit_w'(DATA_BITS - 1);

	tx_state_t state;
	logic [tick_w-1:0] tick_cnt;
	logic [bit_w-1:0] bit_cnt;

	// Byte being sent, shifted right as bits go out
	data_t shreg;

	// Bit boundary, every OVERSAMPLE ticks
	logic bit_end;

	assign bit_end = tick && (tick_cnt == last_tick);

	//////////////////////////////////////////////////
	// Transmit FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state    <= tx_idle;
			tick_cnt <= '0;
			bit_cnt  <= '0;
			tx       <= 1'b1;
			tx_busy  <= 1'b0;
		end
		else
		begin
			// Bit timer runs in every active state
			if (state != tx_idle && tick)
				tick_cnt <= bit_end ? '0 : tick_cnt + 1'b1;

			case (state)
				tx_idle:
				begin
					if (tx_start)
					begin
						// Busy right away, start bit waits for a tick
						tx_busy <= 1'b1;
					end
					else if (tx_busy && tick)
					begin
						tx       <= 1'b0;
						tick_cnt <= '0;
						state    <= uart_pkg::tx_start;
					end
				end
				uart_pkg::tx_start:
				begin
					if (bit_end)
					begin
						tx      <= shreg[0];
						bit_cnt <= '0;
						state   <= tx_data;
					end
				end
				tx_data:
				begin
					if (bit_end)
					begin
						if (bit_cnt == last_bit)
						begin
							// Stop bit
							tx    <= 1'b1;
							state <= tx_stop;
						end
						else
						begin
							tx      <= shreg[0];
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				tx_stop:
				begin
					// Free only after the full stop bit
					if (bit_end)
					begin
						tx_busy <= 1'b0;
						state   <= tx_idle;
					end
				end
				default:
				begin
					tx    <= 1'b1;
					state <= tx_idle;
				end
			endcase
		end
	end

	// Latch on start, then drop one bit per boundary
	always_ff @(posedge clk)
	begin
		if (state == tx_idle && tx_start)
			shreg <= tx_byte;
		else if ((state == uart_pkg::tx_start || state == tx_data) && bit_end)
			shreg <= shreg >> 1;
	end

endmodule

`default_nettype wire

// File: verif/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
	parameter int half_period = 10,
	parameter int reset_cycles = 4
) (
	output logic clk,
	output logic rst_n
);

	// Free-running clock, 20 ns period
	initial
	begin
		clk = 1'b0;
		forever #(half_period) clk = ~clk;
	end

	// Reset low over the first rising edges
	// Released on a falling edge, away from the sampling edge
	initial
	begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// File: verif/uart_assert.sv
`timescale 1ns/10ps
`default_nettype none

module uart_assert (
	input wire clk,
	input wire rst_n,
	input wire rd,
	input wire rx_done,
	input wire rx_empty,
	input wire rx_overrun,
	input wire tx,
	input wire tx_busy
);

	// Number of assertion failures so far
	int unsigned fail_count = 0;

	//////////////////////////////////////////////////
	// Receive holding register flags
	//////////////////////////////////////////////////

	// Overrun only fires on a capture, which also clears empty
	a_empty_overrun: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(rx_empty && rx_overrun)
	) else
	begin
		$error("rx_empty and rx_overrun high together");
		fail_count++;
	end

	// Read of a held byte frees the register next cycle
	// Capture in the same cycle takes priority
	a_read_frees: assert property (
		@(posedge clk) disable iff (!rst_n)
		(rd && !rx_empty && !rx_done) |=> rx_empty
	) else
	begin
		$error("rx_empty did not rise one cycle after rd");
		fail_count++;
	end

	//////////////////////////////////////////////////
	// Serial line
	//////////////////////////////////////////////////

	// Idle serializer keeps the line at the stop level
	a_idle_line: assert property (
		@(posedge clk) disable iff (!rst_n)
		!tx_busy |-> tx
	) else
	begin
		$error("tx low while tx_busy is low");
		fail_count++;
	end

endmodule

// Receive side with the transmit inputs tied off
bind rx_buffer uart_assert u_rx_assert (
	.clk        (clk),
	.rst_n      (rst_n),
	.rd         (rd),
	.rx_done    (rx_done),
	.rx_empty   (rx_empty),
	.rx_overrun (rx_overrun),
	.tx         (1'b1),
	.tx_busy    (1'b1)
);

// Transmit side with the receive inputs held at their reset values
bind uart_tx uart_assert u_tx_assert (
	.clk        (clk),
	.rst_n      (rst_n),
	.rd         (1'b0),
	.rx_done    (1'b0),
	.rx_empty   (1'b1),
	.rx_overrun (1'b0),
	.tx         (tx),
	.tx_busy    (tx_busy)
);

`default_nettype wire

// File: verif/uart_tb.sv
`timescale 1ns/10ps
`default_nettype none

module uart_tb;
	import uart_pkg::*;

	//////////////////////////////////////////////////
	// Timing derived from the divider
	//////////////////////////////////////////////////

	localparam div_t clk_div = 16'd4;
	localparam int bit_cycles = int'(OVERSAMPLE) * int'(clk_div);
	localparam int frame_cycles = 10 * bit_cycles;
	localparam int n_entries = 10;
	// Two frames per entry plus reset and gaps
	localparam int watchdog_cycles = n_entries * 2 * frame_cycles + 1000;
	// Longest wait for a single flag
	localparam int flag_limit = 2 * frame_cycles;

	typedef enum logic [2:0] {
		m_loop,
		m_direct,
		m_overrun,
		m_frame,
		m_backpressure
	} mode_t;

	// One table row where rnd replaces both bytes with a random one
	typedef struct packed {
		mode_t mode;
		logic  rnd;
		data_t din;
		data_t dexp;
	} entry_t;

	entry_t stim_tab [n_entries];

	logic clk;
	logic rst_n;
	logic rx;
	logic tx;
	logic rd;
	logic wr;
	data_t w_data;
	data_t r_data;
	logic rx_empty;
	logic rx_overrun;
	logic frame_err;
	logic tx_full;

	// Serial driver output and loopback select
	logic rx_drv;
	logic loopback;

	logic [31:0] rng;

	// Pulse counters
	int ov_count = 0;
	int fe_count = 0;

	tb_clock u_clock (
		.clk   (clk),
		.rst_n (rst_n)
	);

	uart_top #(
		.clk_div (clk_div)
	) u_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.rx         (rx),
		.tx         (tx),
		.rd         (rd),
		.r_data     (r_data),
		.rx_empty   (rx_empty),
		.rx_overrun (rx_overrun),
		.frame_err  (frame_err),
		.wr         (wr),
		.w_data     (w_data),
		.tx_full    (tx_full)
	);

	// Loopback closes tx onto rx
	assign rx = loopback ? tx : rx_drv;

	// One-cycle pulses counted away from the active edge
	always @(negedge clk)
	begin
		if (rst_n && rx_overrun)
			ov_count <= ov_count + 1;
		if (rst_n && frame_err)
			fe_count <= fe_count + 1;
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check_byte(input data_t got, input data_t exp, input string what);
		if (got !== exp)
			abort_run($sformatf("error at %0t: %s is %02h, expected %02h",
				$time, what, got, exp));
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp)
			abort_run($sformatf("error at %0t: %s is %b, expected %b",
				$time, what, got, exp));
	endtask

	task automatic wait_rx_ready();
		int n;
		n = 0;
		while (rx_empty && n < flag_limit)
		begin
			@(negedge clk);
			n++;
		end
		if (rx_empty)
			abort_run("timed out waiting for rx_empty to fall");
	endtask

	task automatic wait_tx_free();
		int n;
		n = 0;
		while (tx_full && n < flag_limit)
		begin
			@(negedge clk);
			n++;
		end
		if (tx_full)
			abort_run("timed out waiting for tx_full to fall");
	endtask

	// Start, 8 data bits LSB first, stop
	task automatic send_frame(input data_t b, input logic good_stop);
		logic [9:0] frame;
		frame = {good_stop, b, 1'b0};
		for (int i = 0; i < 10; i++)
		begin
			rx_drv = frame[i];
			repeat (bit_cycles) @(negedge clk);
		end
		rx_drv = 1'b1;
		// Low stop bit needs an idle bit so the next start has an edge
		if (!good_stop)
			repeat (bit_cycles) @(negedge clk);
	endtask

	task automatic pulse_write(input data_t b);
		wr = 1'b1;
		w_data = b;
		@(negedge clk);
		wr = 1'b0;
	endtask

	task automatic write_byte(input data_t b);
		wait_tx_free();
		pulse_write(b);
	endtask

	task automatic read_byte();
		rd = 1'b1;
		@(negedge clk);
		rd = 1'b0;
		@(negedge clk);
		check_flag(rx_empty, 1'b1, "rx_empty after rd");
	endtask

	task automatic receive_check(input data_t exp, input string what);
		wait_rx_ready();
		check_byte(r_data, exp, what);
		read_byte();
	endtask

	task automatic fill_table();
		stim_tab[0] = '{m_loop, 1'b0, 8'h55, 8'h55};
		stim_tab[1] = '{m_loop, 1'b0, 8'ha3, 8'ha3};
		stim_tab[2] = '{m_direct, 1'b1, 8'h00, 8'h00};
		stim_tab[3] = '{m_direct, 1'b1, 8'h00, 8'h00};
		stim_tab[4] = '{m_direct, 1'b1, 8'h00, 8'h00};
		// Overrun where the second byte overwrites the first
		stim_tab[5] = '{m_overrun, 1'b0, 8'h3c, 8'hc3};
		// Bad frame followed by a good one
		stim_tab[6] = '{m_frame, 1'b0, 8'h81, 8'h7e};
		stim_tab[7] = '{m_backpressure, 1'b0, 8'h12, 8'h34};
		stim_tab[8] = '{m_loop, 1'b1, 8'h00, 8'h00};
		stim_tab[9] = '{m_direct, 1'b0, 8'h00, 8'h00};
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial
	begin
		entry_t e;
		int ov_before;
		int fe_before;
		$timeformat(-9, 0, " ns", 0);
		rd = 1'b0;
		wr = 1'b0;
		w_data = '0;
		rx_drv = 1'b1;
		loopback = 1'b0;
		rng = 32'he836;
		fill_table();

		@(posedge rst_n);
		@(negedge clk);
		check_flag(tx, 1'b1, "tx after reset");
		check_flag(rx_empty, 1'b1, "rx_empty after reset");
		check_flag(tx_full, 1'b0, "tx_full after reset");
		check_flag(rx_overrun, 1'b0, "rx_overrun after reset");
		check_flag(frame_err, 1'b0, "frame_err after reset");

		for (int i = 0; i < n_entries; i++)
		begin
			e = stim_tab[i];
			if (e.rnd)
			begin
				rng = xorshift32(rng);
				e.din = rng[7:0];
				e.dexp = rng[7:0];
			end
			ov_before = ov_count;
			fe_before = fe_count;
			case (e.mode)
				m_loop:
				begin
					loopback = 1'b1;
					write_byte(e.din);
					receive_check(e.dexp, "loopback r_data");
				end
				m_direct:
				begin
					loopback = 1'b0;
					send_frame(e.din, 1'b1);
					receive_check(e.dexp, "direct r_data");
					check_flag(fe_count != fe_before, 1'b0, "frame_err on good frame");
				end
				m_overrun:
				begin
					loopback = 1'b0;
					send_frame(e.din, 1'b1);
					wait_rx_ready();
					check_byte(r_data, e.din, "r_data before overrun");
					send_frame(e.dexp, 1'b1);
					check_flag(ov_count == ov_before + 1, 1'b1, "single rx_overrun pulse");
					check_flag(rx_empty, 1'b0, "rx_empty after overrun");
					check_byte(r_data, e.dexp, "r_data after overrun");
					read_byte();
				end
				m_frame:
				begin
					loopback = 1'b0;
					send_frame(e.din, 1'b0);
					check_flag(fe_count == fe_before + 1, 1'b1, "single frame_err pulse");
					check_flag(rx_empty, 1'b1, "rx_empty after framing error");
					send_frame(e.dexp, 1'b1);
					receive_check(e.dexp, "r_data after framing error");
				end
				m_backpressure:
				begin
					loopback = 1'b1;
					wait_tx_free();
					pulse_write(e.din);
					check_flag(tx_full, 1'b1, "tx_full after write");
					// Written while full and dropped
					pulse_write(~e.din);
					write_byte(e.dexp);
					receive_check(e.din, "first byte under back-pressure");
					receive_check(e.dexp, "byte written after tx_full fell");
				end
				default:
				begin
					abort_run("stimulus table holds an unknown mode");
				end
			endcase
		end

		if (u_dut.u_rx_buffer.u_rx_assert.fail_count != 0
			|| u_dut.u_uart_tx.u_tx_assert.fail_count != 0)
		begin
			abort_run("one or more bound assertions failed during the run");
		end
		else
		begin
			$display("All tests passed");
			$finish;
		end
	end

	// Watchdog
	initial
	begin
		repeat (watchdog_cycles) @(posedge clk);
		abort_run("run hung waiting for a flag, watchdog expired");
	end

endmodule

`default_nettype wire
